// ==== alu_defs.svh ====
`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

// datapath width of the integer unit
`define ALU_XLEN 64

// shift count field taken from operand b
`define ALU_SHAMT_W 6

// one multiplier bit per iteration
`define ALU_MUL_ITER 64

// counter must reach ALU_MUL_ITER itself
`define ALU_CNT_W 7

`endif

// ==== alu_op_pkg.sv ====
package alu_op_pkg;

  // operations handled by the integer unit
  typedef enum logic [4:0] {
    ALUOP_ADD,
    ALUOP_SUB,
    ALUOP_AND,
    ALUOP_OR,
    ALUOP_XOR,
    ALUOP_SLL,
    ALUOP_SRL,
    ALUOP_SRA,
    ALUOP_SLLW,
    ALUOP_SRLW,
    ALUOP_SRAW,
    ALUOP_SLT,
    ALUOP_SLTU,
    ALUOP_BEQ,
    ALUOP_BNE,
    ALUOP_BLT,
    ALUOP_BGE,
    ALUOP_BLTU,
    ALUOP_BGEU,
    ALUOP_MUL,
    ALUOP_MULH,
    ALUOP_MULHSU,
    ALUOP_MULHU,
    ALUOP_MULW
  } aluop_e;

  // result source groups
  typedef enum logic [2:0] {
    ARITH,
    LOGIC,
    SHIFT,
    CMP,
    MUL
  } op_class_e;

endpackage

// ==== alu_data_pkg.sv ====
`include "alu_defs.svh"

package alu_data_pkg;

  typedef logic [`ALU_XLEN-1:0]   xlen_t;   // operand or result
  typedef logic [2*`ALU_XLEN-1:0] dxlen_t;  // full product
  typedef logic [`ALU_SHAMT_W-1:0] shamt_t;
  typedef logic [`ALU_CNT_W-1:0]   cnt_t;

  // operands and signedness handed to the multiplier
  typedef struct packed {
    xlen_t rs1;
    xlen_t rs2;
    logic  rs1_signed;
    logic  rs2_signed;
  } mul_req_t;

  // multiplier sequencing
  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    DONE
  } ctrl_state_e;

endpackage

// ==== alu_addsub_cmp.sv ====
`timescale 1ns/1ps
`include "alu_defs.svh"

module alu_addsub_cmp (
  input  alu_data_pkg::xlen_t  a_i,
  input  alu_data_pkg::xlen_t  b_i,
  input  logic                 sub_i,
  input  alu_op_pkg::aluop_e   cmp_op_i,
  output alu_data_pkg::xlen_t  sum_o,
  output logic                 compare_o
);

  logic [`ALU_XLEN:0] a_ext;
  logic [`ALU_XLEN:0] b_ext;
  logic [`ALU_XLEN:0] sum_ext;
  logic zf, sf, of, cf, c_top;
  logic lt_s, lt_u;
  logic is_cmp;

  // double sign bit, b inverted for subtract
  assign a_ext   = {a_i[`ALU_XLEN-1], a_i};
  assign b_ext   = {b_i[`ALU_XLEN-1], b_i} ^ {(`ALU_XLEN+1){sub_i}};
  assign sum_ext = a_ext + b_ext + {{`ALU_XLEN{1'b0}}, sub_i};
  assign sum_o   = sum_ext[`ALU_XLEN-1:0];

  // carry out of bit 63 recovered from the extended sign bits
  assign c_top = a_ext[`ALU_XLEN] ^ b_ext[`ALU_XLEN] ^ sum_ext[`ALU_XLEN];

  assign zf = (sum_ext == '0);
  assign sf = sum_ext[`ALU_XLEN-1];
  assign of = sum_ext[`ALU_XLEN] ^ sum_ext[`ALU_XLEN-1];
  assign cf = sub_i ^ c_top;  // borrow on subtract

  assign lt_s = sf ^ of;
  assign lt_u = cf;

  always_comb begin
    is_cmp = 1'b1;
    unique case (cmp_op_i)
      alu_op_pkg::ALUOP_SLT, alu_op_pkg::ALUOP_BLT:   compare_o = lt_s;
      alu_op_pkg::ALUOP_SLTU, alu_op_pkg::ALUOP_BLTU: compare_o = lt_u;
      alu_op_pkg::ALUOP_BEQ:  compare_o = zf;
      alu_op_pkg::ALUOP_BNE:  compare_o = ~zf;
      alu_op_pkg::ALUOP_BGE:  compare_o = ~lt_s;
      alu_op_pkg::ALUOP_BGEU: compare_o = ~lt_u;
      default: begin
        compare_o = 1'b0;
        is_cmp    = 1'b0;
      end
    endcase
  end

  always_comb begin
    if (is_cmp) begin
      assert (!$isunknown(compare_o))
        else $error("compare_o unknown during compare op");
    end
  end

endmodule

// ==== alu_shift.sv ====
`timescale 1ns/1ps
`include "alu_defs.svh"

module alu_shift (
  input  alu_data_pkg::xlen_t  num_i,
  input  alu_data_pkg::shamt_t count_i,
  input  alu_op_pkg::aluop_e   op_i,
  output alu_data_pkg::xlen_t  shift_o
);

  logic [31:0] word;
  logic [4:0]  wcount;  // word forms only use 5 bits
  logic [31:0] word_res;

  assign word   = num_i[31:0];
  assign wcount = count_i[4:0];

  always_comb begin
    word_res = '0;
    shift_o  = '0;
    unique case (op_i)
      alu_op_pkg::ALUOP_SLL: shift_o = num_i << count_i;
      alu_op_pkg::ALUOP_SRL: shift_o = num_i >> count_i;
      alu_op_pkg::ALUOP_SRA: shift_o = $signed(num_i) >>> count_i;
      alu_op_pkg::ALUOP_SLLW: word_res = word << wcount;
      alu_op_pkg::ALUOP_SRLW: word_res = word >> wcount;
      alu_op_pkg::ALUOP_SRAW: word_res = $signed(word) >>> wcount;
      default: shift_o = '0;
    endcase
    if (op_i == alu_op_pkg::ALUOP_SLLW || op_i == alu_op_pkg::ALUOP_SRLW ||
        op_i == alu_op_pkg::ALUOP_SRAW) begin
      shift_o = {{(`ALU_XLEN-32){1'b0}}, word_res};  // sign ext left to execute
    end
  end

endmodule

// ==== alu_mul_ctrl.sv ====
`timescale 1ns/1ps

module alu_mul_ctrl (
  input  logic clk,
  input  logic arst_n_i,
  input  logic mul_valid_i,
  output logic mul_ready_o,
  output logic load_o,
  output logic step_o,
  input  logic last_i
);

  alu_data_pkg::ctrl_state_e state_q;
  alu_data_pkg::ctrl_state_e state_d;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      alu_data_pkg::IDLE: if (mul_valid_i) state_d = alu_data_pkg::BUSY;
      alu_data_pkg::BUSY: if (last_i) state_d = alu_data_pkg::DONE;
      alu_data_pkg::DONE: state_d = alu_data_pkg::IDLE;  // single cycle
      default: state_d = alu_data_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= alu_data_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // load lands on the same edge that leaves IDLE
  assign load_o      = (state_q == alu_data_pkg::IDLE) & mul_valid_i;
  assign step_o      = (state_q == alu_data_pkg::BUSY);
  assign mul_ready_o = (state_q == alu_data_pkg::DONE);  // product valid here

  // the multiply op must be held by the pipeline until the result is taken
  a_valid_held : assert property (
    @(posedge clk) disable iff (!arst_n_i)
    (state_q != alu_data_pkg::IDLE) |-> mul_valid_i
  ) else $error("mul_valid dropped while multiply in flight");

endmodule

// ==== alu_mul_counter.sv ====
`timescale 1ns/1ps
`include "alu_defs.svh"

module alu_mul_counter (
  input  logic clk,
  input  logic arst_n_i,
  input  logic load_i,
  input  logic step_i,
  output logic last_o
);

  alu_data_pkg::cnt_t cnt_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else if (load_i) begin
      cnt_q <= '0;
    end else if (step_i) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign last_o = step_i && (cnt_q == alu_data_pkg::cnt_t'(`ALU_MUL_ITER - 1));

  // controller must leave BUSY on the last step
  a_no_overrun : assert property (
    @(posedge clk) disable iff (!arst_n_i)
    step_i |-> (cnt_q != alu_data_pkg::cnt_t'(`ALU_MUL_ITER))
  ) else $error("multiplier stepped past final iteration");

endmodule

// ==== alu_mul_datapath.sv ====
`timescale 1ns/1ps
`include "alu_defs.svh"

module alu_mul_datapath (
  input  logic                   clk,
  input  logic                   arst_n_i,
  input  logic                   load_i,
  input  logic                   step_i,
  input  alu_data_pkg::mul_req_t req_i,
  output alu_data_pkg::dxlen_t   product_o
);

  logic                 rs1_neg;
  logic                 rs2_neg;
  alu_data_pkg::xlen_t  rs1_mag;
  alu_data_pkg::xlen_t  rs2_mag;
  alu_data_pkg::dxlen_t mcand_q;   // shifted left once per step
  alu_data_pkg::xlen_t  mplier_q;  // lsb examined each step
  alu_data_pkg::dxlen_t acc_q;
  logic                 neg_q;

  // negative only when the operand is treated as signed
  assign rs1_neg = req_i.rs1_signed & req_i.rs1[`ALU_XLEN-1];
  assign rs2_neg = req_i.rs2_signed & req_i.rs2[`ALU_XLEN-1];
  assign rs1_mag = rs1_neg ? -req_i.rs1 : req_i.rs1;
  assign rs2_mag = rs2_neg ? -req_i.rs2 : req_i.rs2;

  always_ff @(posedge clk) begin
    if (load_i) begin
      mcand_q  <= {{`ALU_XLEN{1'b0}}, rs1_mag};
      mplier_q <= rs2_mag;
    end else if (step_i) begin
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      acc_q <= '0;
      neg_q <= 1'b0;
    end else if (load_i) begin
      acc_q <= '0;
      neg_q <= rs1_neg ^ rs2_neg;
    end else if (step_i && mplier_q[0]) begin
      acc_q <= acc_q + mcand_q;
    end
  end

  // magnitude product back to two's complement
  assign product_o = neg_q ? -acc_q : acc_q;

endmodule

// ==== alu_top.sv ====
`timescale 1ns/1ps
`include "alu_defs.svh"

module alu_top (
  input  logic                clk,
  input  logic                arst_n_i,
  input  alu_data_pkg::xlen_t alu_a_i,
  input  alu_data_pkg::xlen_t alu_b_i,
  input  alu_op_pkg::aluop_e  alu_op_i,
  output alu_data_pkg::xlen_t alu_out_o,
  output logic                alu_stall_req_o,
  output logic                compare_out_o
);

  alu_op_pkg::op_class_e  op_class;
  logic                   sub_en;
  logic                   mul_valid;
  logic                   mul_ready;
  logic                   mul_load;
  logic                   mul_step;
  logic                   mul_last;
  alu_data_pkg::mul_req_t mul_req;
  alu_data_pkg::dxlen_t   product;
  alu_data_pkg::xlen_t    sum;
  alu_data_pkg::xlen_t    shift_res;
  alu_data_pkg::xlen_t    logic_res;
  alu_data_pkg::shamt_t   shamt;
  logic                   cmp_bit;

  always_comb begin
    unique case (alu_op_i)
      alu_op_pkg::ALUOP_ADD, alu_op_pkg::ALUOP_SUB: op_class = alu_op_pkg::ARITH;
      alu_op_pkg::ALUOP_AND, alu_op_pkg::ALUOP_OR,
      alu_op_pkg::ALUOP_XOR: op_class = alu_op_pkg::LOGIC;
      alu_op_pkg::ALUOP_SLL, alu_op_pkg::ALUOP_SRL, alu_op_pkg::ALUOP_SRA,
      alu_op_pkg::ALUOP_SLLW, alu_op_pkg::ALUOP_SRLW,
      alu_op_pkg::ALUOP_SRAW: op_class = alu_op_pkg::SHIFT;
      alu_op_pkg::ALUOP_MUL, alu_op_pkg::ALUOP_MULH, alu_op_pkg::ALUOP_MULHSU,
      alu_op_pkg::ALUOP_MULHU, alu_op_pkg::ALUOP_MULW: op_class = alu_op_pkg::MUL;
      default: op_class = alu_op_pkg::CMP;  // slt, sltu and branches
    endcase
  end

  // compares run through the subtractor
  assign sub_en    = (alu_op_i == alu_op_pkg::ALUOP_SUB) || (op_class == alu_op_pkg::CMP);
  assign mul_valid = (op_class == alu_op_pkg::MUL);

  assign mul_req.rs1        = alu_a_i;
  assign mul_req.rs2        = alu_b_i;
  assign mul_req.rs1_signed = (alu_op_i != alu_op_pkg::ALUOP_MULHU);
  assign mul_req.rs2_signed = (alu_op_i != alu_op_pkg::ALUOP_MULHU) &&
                              (alu_op_i != alu_op_pkg::ALUOP_MULHSU);

  always_comb begin
    unique case (alu_op_i)
      alu_op_pkg::ALUOP_AND: logic_res = alu_a_i & alu_b_i;
      alu_op_pkg::ALUOP_OR:  logic_res = alu_a_i | alu_b_i;
      default:               logic_res = alu_a_i ^ alu_b_i;
    endcase
  end

  assign shamt = alu_b_i[`ALU_SHAMT_W-1:0];

  alu_addsub_cmp u_addsub_cmp (
    .a_i       (alu_a_i),
    .b_i       (alu_b_i),
    .sub_i     (sub_en),
    .cmp_op_i  (alu_op_i),
    .sum_o     (sum),
    .compare_o (cmp_bit)
  );

  alu_shift u_shift (
    .num_i   (alu_a_i),
    .count_i (shamt),
    .op_i    (alu_op_i),
    .shift_o (shift_res)
  );

  alu_mul_ctrl u_mul_ctrl (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .mul_valid_i (mul_valid),
    .mul_ready_o (mul_ready),
    .load_o      (mul_load),
    .step_o      (mul_step),
    .last_i      (mul_last)
  );

  alu_mul_counter u_mul_counter (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .load_i   (mul_load),
    .step_i   (mul_step),
    .last_o   (mul_last)
  );

  alu_mul_datapath u_mul_datapath (
    .clk       (clk),
    .arst_n_i  (arst_n_i),
    .load_i    (mul_load),
    .step_i    (mul_step),
    .req_i     (mul_req),
    .product_o (product)
  );

  always_comb begin
    unique case (op_class)
      alu_op_pkg::ARITH: alu_out_o = sum;
      alu_op_pkg::LOGIC: alu_out_o = logic_res;
      alu_op_pkg::SHIFT: alu_out_o = shift_res;
      alu_op_pkg::CMP:   alu_out_o = {{(`ALU_XLEN-1){1'b0}}, cmp_bit};
      alu_op_pkg::MUL: begin
        if (alu_op_i == alu_op_pkg::ALUOP_MUL) begin
          alu_out_o = product[`ALU_XLEN-1:0];
        end else if (alu_op_i == alu_op_pkg::ALUOP_MULW) begin
          alu_out_o = {{(`ALU_XLEN-32){1'b0}}, product[31:0]};  // no sign ext here
        end else begin
          alu_out_o = product[2*`ALU_XLEN-1:`ALU_XLEN];  // mulh, mulhsu, mulhu
        end
      end
      default: alu_out_o = '0;
    endcase
  end

  assign compare_out_o   = cmp_bit;
  assign alu_stall_req_o = mul_valid & ~mul_ready;  // hold pipe until DONE

endmodule

// ==== tb_clkgen.sv ====
`timescale 1ns/1ps

module tb_clkgen (
  output logic clk_o,
  output logic arst_n_o
);

  localparam int HALF_PERIOD = 50;  // 100 ns clock

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // reset held for three rising edges, released away from them
  initial begin
    arst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

// ==== tb_alu_top.sv ====
`timescale 1ns/1ps
`include "alu_defs.svh"

module tb_alu_top;

  localparam int NUM_MUL   = 18;  // 15 in test 4, 3 in test 5
  localparam int MUL_STALL = 65;
  localparam alu_data_pkg::xlen_t MIN_NEG = {1'b1, {(`ALU_XLEN-1){1'b0}}};
  localparam alu_data_pkg::xlen_t ALL_ONE = '1;

  logic                clk;
  logic                arst_n;
  alu_data_pkg::xlen_t a;
  alu_data_pkg::xlen_t b;
  alu_op_pkg::aluop_e  op;
  alu_data_pkg::xlen_t out;
  logic                stall;
  logic                cmp;
  int                  errors = 0;
  int                  checks = 0;
  logic [63:0]         rng = 64'd7;

  tb_clkgen i_clkgen (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  alu_top i_dut (
    .clk             (clk),
    .arst_n_i        (arst_n),
    .alu_a_i         (a),
    .alu_b_i         (b),
    .alu_op_i        (op),
    .alu_out_o       (out),
    .alu_stall_req_o (stall),
    .compare_out_o   (cmp)
  );

  function automatic alu_data_pkg::xlen_t xorshift64();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 7);
    rng = rng ^ (rng << 17);
    return rng;
  endfunction

  function automatic logic model_cmp(alu_op_pkg::aluop_e o, alu_data_pkg::xlen_t x,
                                     alu_data_pkg::xlen_t y);
    case (o)
      alu_op_pkg::ALUOP_SLT, alu_op_pkg::ALUOP_BLT:   return $signed(x) < $signed(y);
      alu_op_pkg::ALUOP_SLTU, alu_op_pkg::ALUOP_BLTU: return x < y;
      alu_op_pkg::ALUOP_BEQ:  return x == y;
      alu_op_pkg::ALUOP_BNE:  return x != y;
      alu_op_pkg::ALUOP_BGE:  return $signed(x) >= $signed(y);
      alu_op_pkg::ALUOP_BGEU: return x >= y;
      default: return 1'b0;
    endcase
  endfunction

  function automatic alu_data_pkg::xlen_t model_result(alu_op_pkg::aluop_e o,
                                                      alu_data_pkg::xlen_t x,
                                                      alu_data_pkg::xlen_t y);
    logic [31:0]          w;
    alu_data_pkg::dxlen_t sx;  // operands widened for the full product
    alu_data_pkg::dxlen_t ux;
    alu_data_pkg::dxlen_t sy;
    alu_data_pkg::dxlen_t uy;
    alu_data_pkg::dxlen_t p;
    sx = {{`ALU_XLEN{x[`ALU_XLEN-1]}}, x};
    sy = {{`ALU_XLEN{y[`ALU_XLEN-1]}}, y};
    ux = {{`ALU_XLEN{1'b0}}, x};
    uy = {{`ALU_XLEN{1'b0}}, y};
    case (o)
      alu_op_pkg::ALUOP_ADD:  return x + y;
      alu_op_pkg::ALUOP_SUB:  return x - y;
      alu_op_pkg::ALUOP_AND:  return x & y;
      alu_op_pkg::ALUOP_OR:   return x | y;
      alu_op_pkg::ALUOP_XOR:  return x ^ y;
      alu_op_pkg::ALUOP_SLL:  return x << y[5:0];
      alu_op_pkg::ALUOP_SRL:  return x >> y[5:0];
      alu_op_pkg::ALUOP_SRA:  return $signed(x) >>> y[5:0];
      alu_op_pkg::ALUOP_SLLW: begin
        w = x[31:0] << y[4:0];
        return {32'h0, w};
      end
      alu_op_pkg::ALUOP_SRLW: begin
        w = x[31:0] >> y[4:0];
        return {32'h0, w};
      end
      alu_op_pkg::ALUOP_SRAW: begin
        w = $signed(x[31:0]) >>> y[4:0];
        return {32'h0, w};  // word results stay zero-extended
      end
      alu_op_pkg::ALUOP_MUL: begin
        p = ux * uy;
        return p[63:0];
      end
      alu_op_pkg::ALUOP_MULW: begin
        p = ux * uy;
        return {32'h0, p[31:0]};
      end
      alu_op_pkg::ALUOP_MULH: begin
        p = sx * sy;
        return p[127:64];
      end
      alu_op_pkg::ALUOP_MULHSU: begin
        p = sx * uy;
        return p[127:64];
      end
      alu_op_pkg::ALUOP_MULHU: begin
        p = ux * uy;
        return p[127:64];
      end
      default: return {63'h0, model_cmp(o, x, y)};
    endcase
  endfunction

  task automatic check_xlen(string name, alu_data_pkg::xlen_t exp, alu_data_pkg::xlen_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // one combinational op, checked 10 ns after the falling edge
  task automatic run_comb(alu_op_pkg::aluop_e o, alu_data_pkg::xlen_t x,
                          alu_data_pkg::xlen_t y, bit with_cmp);
    @(negedge clk);
    op = o;
    a  = x;
    b  = y;
    #10;
    check_xlen($sformatf("alu_out_o (%s)", o.name()), model_result(o, x, y), out);
    check_bit($sformatf("alu_stall_req_o (%s)", o.name()), 1'b0, stall);
    if (with_cmp) check_bit($sformatf("compare_out_o (%s)", o.name()), model_cmp(o, x, y), cmp);
  endtask

  task automatic run_mul(alu_op_pkg::aluop_e o, alu_data_pkg::xlen_t x, alu_data_pkg::xlen_t y);
    int n;
    @(negedge clk);
    op = o;
    a  = x;
    b  = y;
    #10;
    n = 0;
    while (stall === 1'b1 && n < 100) begin
      n++;
      @(negedge clk);
      #10;
    end
    checks++;
    if (n >= 100) begin
      errors++;
      $display("%s never finished, stall still high after 100 cycles", o.name());
    end else if (n != MUL_STALL) begin
      errors++;
      $display("%s held stall for %0d cycles instead of %0d", o.name(), n, MUL_STALL);
    end
    check_xlen($sformatf("alu_out_o (%s)", o.name()), model_result(o, x, y), out);
  endtask

  task automatic report_test(int num, string what, int err_before);
    $display("test %0d %s finished with %0d errors", num, what, errors - err_before);
  endtask

  task automatic test_arith_logic();
    alu_op_pkg::aluop_e  ops [5];
    alu_data_pkg::xlen_t ea [3];
    alu_data_pkg::xlen_t eb [3];
    int                  e0;
    e0  = errors;
    ops = '{alu_op_pkg::ALUOP_ADD, alu_op_pkg::ALUOP_SUB, alu_op_pkg::ALUOP_AND,
            alu_op_pkg::ALUOP_OR, alu_op_pkg::ALUOP_XOR};
    ea  = '{~MIN_NEG, MIN_NEG, ALL_ONE};  // overflow and wrap corners
    eb  = '{64'h1, ALL_ONE, ALL_ONE};
    foreach (ops[i]) begin
      for (int k = 0; k < 20; k++) run_comb(ops[i], xorshift64(), xorshift64(), 1'b0);
      foreach (ea[k]) run_comb(ops[i], ea[k], eb[k], 1'b0);
    end
    report_test(1, "add/sub/logic", e0);
  endtask

  task automatic test_shifts();
    alu_op_pkg::aluop_e  dw [3];
    alu_op_pkg::aluop_e  ww [3];
    alu_data_pkg::xlen_t dcnt [3];
    alu_data_pkg::xlen_t wcnt [3];
    int                  e0;
    e0   = errors;
    dw   = '{alu_op_pkg::ALUOP_SLL, alu_op_pkg::ALUOP_SRL, alu_op_pkg::ALUOP_SRA};
    ww   = '{alu_op_pkg::ALUOP_SLLW, alu_op_pkg::ALUOP_SRLW, alu_op_pkg::ALUOP_SRAW};
    dcnt = '{64'd0, 64'd1, 64'd63};
    wcnt = '{64'd32, 64'd45, 64'd63};  // only the low 5 bits count
    foreach (dw[i]) begin
      foreach (dcnt[k]) run_comb(dw[i], xorshift64(), dcnt[k], 1'b0);
      for (int k = 0; k < 4; k++) run_comb(dw[i], xorshift64(), xorshift64(), 1'b0);
    end
    foreach (ww[i]) begin
      foreach (wcnt[k]) run_comb(ww[i], xorshift64(), wcnt[k], 1'b0);
      run_comb(ww[i], 64'h0123_4567_8000_0001, 64'd4, 1'b0);
    end
    report_test(2, "shifts", e0);
  endtask

  task automatic test_compares();
    alu_data_pkg::xlen_t ca [5];
    alu_data_pkg::xlen_t cb [5];
    int                  e0;
    e0 = errors;
    ca = '{64'd5, -64'sd3, 64'd5, MIN_NEG, MIN_NEG};
    cb = '{64'd5, 64'd5, -64'sd3, 64'd1, MIN_NEG};
    for (int o = alu_op_pkg::ALUOP_SLT; o <= alu_op_pkg::ALUOP_BGEU; o++) begin
      foreach (ca[k]) run_comb(alu_op_pkg::aluop_e'(o), ca[k], cb[k], 1'b1);
    end
    report_test(3, "compares", e0);
  endtask

  task automatic test_multiplies();
    alu_data_pkg::xlen_t ma [3];
    alu_data_pkg::xlen_t mb [3];
    int                  e0;
    e0 = errors;
    ma = '{xorshift64(), -64'sd3, MIN_NEG};
    mb = '{xorshift64(), 64'd7, ALL_ONE};
    for (int o = alu_op_pkg::ALUOP_MUL; o <= alu_op_pkg::ALUOP_MULW; o++) begin
      foreach (ma[k]) run_mul(alu_op_pkg::aluop_e'(o), ma[k], mb[k]);
    end
    report_test(4, "multiplies", e0);
  endtask

  task automatic test_back_to_back();
    int e0;
    e0 = errors;
    run_mul(alu_op_pkg::ALUOP_MULH, xorshift64(), xorshift64());
    run_mul(alu_op_pkg::ALUOP_MULHU, xorshift64(), xorshift64());  // no gap
    run_comb(alu_op_pkg::ALUOP_ADD, xorshift64(), xorshift64(), 1'b0);
    run_mul(alu_op_pkg::ALUOP_MUL, xorshift64(), xorshift64());
    report_test(5, "back to back", e0);
  endtask

  initial begin
    op = alu_op_pkg::ALUOP_ADD;
    a  = '0;
    b  = '0;
    wait (arst_n === 1'b1);
    test_arith_logic();
    test_shifts();
    test_compares();
    test_multiplies();
    test_back_to_back();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // bound from the multiply count plus room for the combinational ops
  initial begin
    repeat (NUM_MUL * 70 + 200) @(posedge clk);
    $display("watchdog expired before the tests completed");
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+.
alu_op_pkg.sv
alu_data_pkg.sv
alu_addsub_cmp.sv
alu_shift.sv
alu_mul_ctrl.sv
alu_mul_counter.sv
alu_mul_datapath.sv
alu_top.sv
tb_clkgen.sv
tb_alu_top.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_alu_top -Mdir obj_dir
	@out=$$(./obj_dir/Vtb_alu_top); echo "$$out"; echo "$$out" | grep -q "^TEST PASSED$$"

clean:
	rm -rf obj_dir
